//--- hdl/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

    localparam int xlen       = 32;
    localparam int reg_count  = 32;
    localparam int dmem_words = 256;
    localparam int dmem_aw    = $clog2(dmem_words); // word index width
    localparam logic [xlen-1:0] reset_pc = '0;

    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_none, alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_or, alu_srl, alu_sra, alu_and,
        alu_lui,  // pass op2
        alu_jalr, // add, clear bit 0
        alu_br    // pass op1
    } alu_func_e;

    typedef enum logic [2:0] {
        br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu
    } br_func_e;

    typedef enum logic [1:0] {
        pc_nextpc, pc_alu, pc_brjmp
    } pc_sel_e;

    typedef enum logic {op1_rs1, op1_pc} op1_sel_e;

    typedef enum logic {op2_rs2, op2_imm} op2_sel_e;

    typedef enum logic [1:0] {
        wb_alu, wb_data, wb_pc4, wb_x
    } wb_sel_e;

    typedef enum logic [2:0] {
        size_none, size_b, size_h, size_w, size_bu, size_hu
    } mem_size_e;

    typedef enum logic {mem_rd, mem_wr} mem_func_e;

    typedef enum logic [1:0] {
        st_fetch, st_execute, st_memory, st_writeback
    } core_state_e;

endpackage

`default_nettype wire

//--- hdl/riscv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_decode (
    input  wire  [31:0]              inst,
    output logic [4:0]               rs1,
    output logic [4:0]               rs2,
    output logic [4:0]               rd,
    output logic [31:0]              imm,
    output riscv_pkg::br_func_e      br_func,
    output riscv_pkg::pc_sel_e       pc_sel,
    output riscv_pkg::op1_sel_e      op1_sel,
    output riscv_pkg::op2_sel_e      op2_sel,
    output riscv_pkg::wb_sel_e       wb_sel,
    output riscv_pkg::alu_func_e     alu_func,
    output logic                     rf_we,
    output riscv_pkg::mem_func_e     mem_func,
    output riscv_pkg::mem_size_e     mem_size,
    output logic                     mem_en
);
    riscv_pkg::opcode_e opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    function automatic riscv_pkg::alu_func_e alu_op(input logic [2:0] f3,
                                                     input logic [6:0] f7,
                                                     input logic reg_form);
        riscv_pkg::alu_func_e op;
        case (f3)
            3'b000: begin
                if (!reg_form || f7 == 7'b0000000)
                    op = riscv_pkg::alu_add;
                else if (f7 == 7'b0100000)
                    op = riscv_pkg::alu_sub;
                else
                    op = riscv_pkg::alu_none;
            end
            3'b001: op = (f7 == 7'b0000000) ? riscv_pkg::alu_sll : riscv_pkg::alu_none;
            3'b010: op = riscv_pkg::alu_slt;
            3'b011: op = riscv_pkg::alu_sltu;
            3'b100: op = riscv_pkg::alu_xor;
            3'b101: begin
                if (f7 == 7'b0000000)
                    op = riscv_pkg::alu_srl;
                else if (f7 == 7'b0100000)
                    op = riscv_pkg::alu_sra;
                else
                    op = riscv_pkg::alu_none;
            end
            3'b110: op = riscv_pkg::alu_or;
            default: op = riscv_pkg::alu_and;
        endcase
        return op;
    endfunction

    function automatic riscv_pkg::mem_size_e size_of(input logic [2:0] f3,
                                                      input logic is_store);
        riscv_pkg::mem_size_e sz;
        case (f3)
            3'b000: sz = riscv_pkg::size_b;
            3'b001: sz = riscv_pkg::size_h;
            3'b010: sz = riscv_pkg::size_w;
            3'b100: sz = is_store ? riscv_pkg::size_none : riscv_pkg::size_bu;
            3'b101: sz = is_store ? riscv_pkg::size_none : riscv_pkg::size_hu;
            default: sz = riscv_pkg::size_none;
        endcase
        return sz;
    endfunction

    assign opcode = riscv_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    assign imm_i = {{21{inst[31]}}, inst[30:20]};
    assign imm_s = {{21{inst[31]}}, inst[30:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        imm      = imm_i; // no-op unless overridden
        br_func  = riscv_pkg::br_none;
        pc_sel   = riscv_pkg::pc_nextpc;
        op1_sel  = riscv_pkg::op1_rs1;
        op2_sel  = riscv_pkg::op2_imm;
        wb_sel   = riscv_pkg::wb_x;
        alu_func = riscv_pkg::alu_none;
        rf_we    = 1'b0;
        mem_func = riscv_pkg::mem_rd;
        mem_size = riscv_pkg::size_none;
        case (opcode)
            riscv_pkg::opc_lui: begin
                imm      = imm_u;
                wb_sel   = riscv_pkg::wb_alu;
                alu_func = riscv_pkg::alu_lui;
                rf_we    = 1'b1;
            end
            riscv_pkg::opc_auipc: begin
                imm      = imm_u;
                op1_sel  = riscv_pkg::op1_pc;
                wb_sel   = riscv_pkg::wb_alu;
                alu_func = riscv_pkg::alu_add;
                rf_we    = 1'b1;
            end
            riscv_pkg::opc_jal: begin
                imm      = imm_j;
                pc_sel   = riscv_pkg::pc_alu;
                op1_sel  = riscv_pkg::op1_pc;
                wb_sel   = riscv_pkg::wb_pc4;
                alu_func = riscv_pkg::alu_add;
                rf_we    = 1'b1;
            end
            riscv_pkg::opc_jalr: begin
                pc_sel   = riscv_pkg::pc_alu;
                wb_sel   = riscv_pkg::wb_pc4;
                alu_func = riscv_pkg::alu_jalr;
                rf_we    = 1'b1;
            end
            riscv_pkg::opc_branch: begin
                imm      = imm_b;
                pc_sel   = riscv_pkg::pc_brjmp;
                op2_sel  = riscv_pkg::op2_rs2;
                alu_func = riscv_pkg::alu_br;
                case (funct3)
                    3'b000: br_func = riscv_pkg::br_eq;
                    3'b001: br_func = riscv_pkg::br_ne;
                    3'b100: br_func = riscv_pkg::br_lt;
                    3'b101: br_func = riscv_pkg::br_ge;
                    3'b110: br_func = riscv_pkg::br_ltu;
                    3'b111: br_func = riscv_pkg::br_geu;
                    default: br_func = riscv_pkg::br_none; // falls through to pc+4
                endcase
            end
            riscv_pkg::opc_load: begin
                wb_sel   = riscv_pkg::wb_data;
                alu_func = riscv_pkg::alu_add;
                mem_size = size_of(funct3, 1'b0);
                rf_we    = (mem_size != riscv_pkg::size_none);
            end
            riscv_pkg::opc_store: begin
                imm      = imm_s;
                alu_func = riscv_pkg::alu_add;
                mem_func = riscv_pkg::mem_wr;
                mem_size = size_of(funct3, 1'b1);
            end
            riscv_pkg::opc_op_imm: begin
                wb_sel   = riscv_pkg::wb_alu;
                alu_func = alu_op(funct3, funct7, 1'b0);
                rf_we    = (alu_func != riscv_pkg::alu_none);
            end
            riscv_pkg::opc_op: begin
                op2_sel  = riscv_pkg::op2_rs2;
                wb_sel   = riscv_pkg::wb_alu;
                alu_func = alu_op(funct3, funct7, 1'b1);
                rf_we    = (alu_func != riscv_pkg::alu_none);
            end
            default: ;
        endcase
    end

    assign mem_en = (mem_size != riscv_pkg::size_none);

endmodule

`default_nettype wire

//--- hdl/riscv_control.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_control (
    input  wire                         clk,
    input  wire                         reset,
    input  wire  [31:0]                 imem_data,
    output logic [31:0]                 pc,
    output logic [31:0]                 inst,
    input  wire  [31:0]                 next_pc,
    input  wire                         rf_we_dec,
    input  wire                         mem_en_dec,
    input  wire  riscv_pkg::mem_func_e  mem_func,
    input  wire  [4:0]                  rd,
    input  wire  [31:0]                 wb_data,
    output logic                        rf_wr,
    output logic                        dmem_strobe,
    output logic                        exec_latch,
    output logic                        retire_valid,
    output logic [31:0]                 retire_pc,
    output logic [4:0]                  retire_rd,
    output logic                        retire_we,
    output logic [31:0]                 retire_wdata
);
    riscv_pkg::core_state_e state;
    logic [31:0] npc_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= riscv_pkg::st_fetch;
            pc    <= riscv_pkg::reset_pc;
        end else begin
            case (state)
                riscv_pkg::st_fetch:   state <= riscv_pkg::st_execute;
                riscv_pkg::st_execute: state <= mem_en_dec ? riscv_pkg::st_memory
                                                           : riscv_pkg::st_writeback;
                riscv_pkg::st_memory:  state <= riscv_pkg::st_writeback;
                default: begin
                    state <= riscv_pkg::st_fetch;
                    pc    <= npc_q; // commit target
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == riscv_pkg::st_fetch)
            inst <= imem_data;
        if (exec_latch)
            npc_q <= next_pc;
    end

    assign exec_latch   = (state == riscv_pkg::st_execute);
    assign dmem_strobe  = (state == riscv_pkg::st_memory) && mem_en_dec;
    assign retire_valid = (state == riscv_pkg::st_writeback);
    assign rf_wr        = retire_valid && rf_we_dec;

    // x0 writes are architecturally invisible, report them as no write
    assign retire_pc    = pc;
    assign retire_we    = rf_wr && (rd != 5'd0);
    assign retire_rd    = retire_we ? rd : 5'd0;
    assign retire_wdata = retire_we ? wb_data : 32'd0;

    assert property (@(posedge clk) disable iff (reset) retire_valid |=> !retire_valid)
        else $error("retire_valid held two cycles");
    assert property (@(posedge clk) disable iff (reset)
                     dmem_strobe == (state == riscv_pkg::st_memory))
        else $error("dmem strobe and MEMORY state disagree");
    assert property (@(posedge clk) disable iff (reset)
                     rf_wr && mem_en_dec |-> mem_func == riscv_pkg::mem_rd)
        else $error("store wrote the register file");

endmodule

`default_nettype wire

//--- hdl/riscv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_alu (
    input  wire  [31:0]                 op1,
    input  wire  [31:0]                 op2,
    input  wire  riscv_pkg::alu_func_e  alu_func,
    output logic [31:0]                 result
);
    logic [31:0] sum;
    logic [4:0]  shamt;

    assign sum   = op1 + op2;
    assign shamt = op2[4:0];

    always_comb begin
        case (alu_func)
            riscv_pkg::alu_add:  result = sum;
            riscv_pkg::alu_sub:  result = op1 - op2;
            riscv_pkg::alu_sll:  result = op1 << shamt;
            riscv_pkg::alu_slt:  result = {31'b0, $signed(op1) < $signed(op2)};
            riscv_pkg::alu_sltu: result = {31'b0, op1 < op2};
            riscv_pkg::alu_xor:  result = op1 ^ op2;
            riscv_pkg::alu_or:   result = op1 | op2;
            riscv_pkg::alu_srl:  result = op1 >> shamt;
            riscv_pkg::alu_sra:  result = $signed(op1) >>> shamt;
            riscv_pkg::alu_and:  result = op1 & op2;
            riscv_pkg::alu_lui:  result = op2;
            riscv_pkg::alu_jalr: result = {sum[31:1], 1'b0};
            riscv_pkg::alu_br:   result = op1;
            default:             result = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/riscv_branch.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_branch (
    input  wire  [31:0]                rs1_data,
    input  wire  [31:0]                rs2_data,
    input  wire  [31:0]                pc,
    input  wire  [31:0]                imm,
    input  wire  [31:0]                alu_result,
    input  wire  riscv_pkg::br_func_e  br_func,
    input  wire  riscv_pkg::pc_sel_e   pc_sel,
    output logic [31:0]                next_pc
);
    logic        taken;
    logic [31:0] pc4;

    assign pc4 = pc + 32'd4;

    always_comb begin
        case (br_func)
            riscv_pkg::br_eq:  taken = (rs1_data == rs2_data);
            riscv_pkg::br_ne:  taken = (rs1_data != rs2_data);
            riscv_pkg::br_lt:  taken = ($signed(rs1_data) < $signed(rs2_data));
            riscv_pkg::br_ge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            riscv_pkg::br_ltu: taken = (rs1_data < rs2_data);
            riscv_pkg::br_geu: taken = (rs1_data >= rs2_data);
            default:           taken = 1'b0;
        endcase
    end

    always_comb begin
        case (pc_sel)
            riscv_pkg::pc_alu:   next_pc = alu_result; // jal/jalr target
            riscv_pkg::pc_brjmp: next_pc = taken ? pc + imm : pc4;
            default:             next_pc = pc4;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/riscv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_regfile (
    input  wire         clk,
    input  wire         reset,
    input  wire  [4:0]  raddr1,
    input  wire  [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  wire         we,
    input  wire  [4:0]  waddr,
    input  wire  [31:0] wdata
);
    logic [31:0] regs [riscv_pkg::reg_count];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < riscv_pkg::reg_count; i++)
                regs[i] <= 32'd0;
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

    assert property (@(posedge clk) disable iff (reset) we && waddr == 5'd0 |=> regs[0] == 32'd0)
        else $error("x0 storage modified");

endmodule

`default_nettype wire

//--- hdl/riscv_dmem.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_dmem (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         strobe,
    input  wire  riscv_pkg::mem_func_e  mem_func,
    input  wire  riscv_pkg::mem_size_e  mem_size,
    input  wire  [31:0]                 addr,
    input  wire  [31:0]                 wdata,
    output logic [31:0]                 rdata
);
    logic [31:0] mem [riscv_pkg::dmem_words];
    logic [riscv_pkg::dmem_aw-1:0] idx;
    logic [1:0]  lane;
    logic [3:0]  be;
    logic [31:0] wshift;
    logic [31:0] lword;

    assign idx    = addr[riscv_pkg::dmem_aw+1:2];
    assign lane   = addr[1:0];
    assign wshift = wdata << {lane, 3'b000}; // move store data to its lane
    assign lword  = mem[idx] >> {lane, 3'b000};

    always_comb begin
        case (mem_size)
            riscv_pkg::size_b: be = 4'b0001 << lane;
            riscv_pkg::size_h: be = 4'b0011 << lane;
            riscv_pkg::size_w: be = 4'b1111;
            default:           be = 4'b0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (strobe && mem_func == riscv_pkg::mem_wr) begin
            for (int i = 0; i < 4; i++)
                if (be[i])
                    mem[idx][8*i +: 8] <= wshift[8*i +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rdata <= 32'd0;
        end else if (strobe && mem_func == riscv_pkg::mem_rd) begin
            case (mem_size)
                riscv_pkg::size_b:  rdata <= {{24{lword[7]}}, lword[7:0]};
                riscv_pkg::size_bu: rdata <= {24'd0, lword[7:0]};
                riscv_pkg::size_h:  rdata <= {{16{lword[15]}}, lword[15:0]};
                riscv_pkg::size_hu: rdata <= {16'd0, lword[15:0]};
                default:            rdata <= lword;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset)
                     strobe && mem_size inside {riscv_pkg::size_h, riscv_pkg::size_hu}
                     |-> !addr[0])
        else $error("misaligned half access");
    assert property (@(posedge clk) disable iff (reset)
                     strobe && mem_size == riscv_pkg::size_w |-> addr[1:0] == 2'b00)
        else $error("misaligned word access");

endmodule

`default_nettype wire

//--- hdl/riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core (
    input  wire         clk,
    input  wire         reset,
    output logic [31:0] imem_addr,
    input  wire  [31:0] imem_data,
    output logic        retire_valid,
    output logic        retire_we,
    output logic [31:0] retire_pc,
    output logic [31:0] retire_wdata,
    output logic [4:0]  retire_rd
);
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] next_pc;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    riscv_pkg::br_func_e  br_func;
    riscv_pkg::pc_sel_e   pc_sel;
    riscv_pkg::op1_sel_e  op1_sel;
    riscv_pkg::op2_sel_e  op2_sel;
    riscv_pkg::wb_sel_e   wb_sel;
    riscv_pkg::alu_func_e alu_func;
    riscv_pkg::mem_func_e mem_func;
    riscv_pkg::mem_size_e mem_size;
    logic        rf_we;
    logic        mem_en;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] alu_result;
    logic [31:0] alu_q;
    logic [31:0] dmem_rdata;
    logic [31:0] wb_data;
    logic        rf_wr;
    logic        dmem_strobe;
    logic        exec_latch;

    assign imem_addr = pc;

    riscv_control u_control (
        .clk(clk), .reset(reset), .imem_data(imem_data), .pc(pc), .inst(inst),
        .next_pc(next_pc), .rf_we_dec(rf_we), .mem_en_dec(mem_en), .mem_func(mem_func),
        .rd(rd), .wb_data(wb_data), .rf_wr(rf_wr), .dmem_strobe(dmem_strobe),
        .exec_latch(exec_latch), .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rd(retire_rd), .retire_we(retire_we), .retire_wdata(retire_wdata)
    );

    riscv_decode u_decode (
        .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .br_func(br_func),
        .pc_sel(pc_sel), .op1_sel(op1_sel), .op2_sel(op2_sel), .wb_sel(wb_sel),
        .alu_func(alu_func), .rf_we(rf_we), .mem_func(mem_func), .mem_size(mem_size),
        .mem_en(mem_en)
    );

    riscv_regfile u_regfile (
        .clk(clk), .reset(reset), .raddr1(rs1), .raddr2(rs2), .rdata1(rs1_data),
        .rdata2(rs2_data), .we(rf_wr), .waddr(rd), .wdata(wb_data)
    );

    assign op1 = (op1_sel == riscv_pkg::op1_pc) ? pc : rs1_data;
    assign op2 = (op2_sel == riscv_pkg::op2_imm) ? imm : rs2_data;

    riscv_alu u_alu (.op1(op1), .op2(op2), .alu_func(alu_func), .result(alu_result));

    riscv_branch u_branch (
        .rs1_data(rs1_data), .rs2_data(rs2_data), .pc(pc), .imm(imm),
        .alu_result(alu_result), .br_func(br_func), .pc_sel(pc_sel), .next_pc(next_pc)
    );

    always_ff @(posedge clk) begin
        if (exec_latch)
            alu_q <= alu_result; // also the data address
    end

    riscv_dmem u_dmem (
        .clk(clk), .reset(reset), .strobe(dmem_strobe), .mem_func(mem_func),
        .mem_size(mem_size), .addr(alu_q), .wdata(rs2_data), .rdata(dmem_rdata)
    );

    always_comb begin
        case (wb_sel)
            riscv_pkg::wb_alu:  wb_data = alu_q;
            riscv_pkg::wb_data: wb_data = dmem_rdata;
            riscv_pkg::wb_pc4:  wb_data = pc + 32'd4; // link value
            default:            wb_data = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

//--- tb/riscv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core_tb;

    localparam int prog_depth     = 128;
    localparam int retire_timeout = 20; // cycles per instruction
    localparam int random_count   = 40;

    logic        clk;
    logic        reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        retire_valid;
    logic        retire_we;
    logic [31:0] retire_pc;
    logic [31:0] retire_wdata;
    logic [4:0]  retire_rd;

    logic [31:0] prog_inst [prog_depth];
    logic [31:0] exp_next  [prog_depth];
    logic [4:0]  exp_rd    [prog_depth];
    logic        exp_we    [prog_depth];
    logic [31:0] exp_wdata [prog_depth];
    logic [31:0] model     [32];
    logic [31:0] row_pc;
    logic [31:0] rng;
    int          errors;

    riscv_core u_riscv_core (
        .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
        .retire_valid(retire_valid), .retire_we(retire_we), .retire_pc(retire_pc),
        .retire_wdata(retire_wdata), .retire_rd(retire_rd)
    );

    assign imem_data = prog_inst[imem_addr[8:2]]; // combinational instruction port

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic put_jump(input logic [31:0] inst, input logic [4:0] rd,
                            input logic [31:0] wdata, input logic [31:0] target);
        prog_inst[row_pc[8:2]] = inst;
        exp_rd[row_pc[8:2]]    = rd;
        exp_we[row_pc[8:2]]    = (rd != 5'd0);
        exp_wdata[row_pc[8:2]] = wdata;
        exp_next[row_pc[8:2]]  = target;
        row_pc = row_pc + 32'd4;
    endtask

    task automatic put_row(input logic [31:0] inst, input logic [4:0] rd,
                           input logic [31:0] wdata);
        put_jump(inst, rd, wdata, row_pc + 32'd4);
    endtask

    task automatic skip_row();
        row_pc = row_pc + 32'd4; // slot keeps its fill word
    endtask

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "stopped on first error");
        end
    endtask

    task automatic wait_retire();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!retire_valid && cycles < retire_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!retire_valid) begin
            $display("no instruction retired within %0d cycles at %0t ns", retire_timeout,
                     $time);
            $display("=== FAIL ===");
            $fatal(1, "retire timeout");
        end
    endtask

    task automatic build_program();
        for (int i = 0; i < prog_depth; i++) begin
            prog_inst[i] = {i[24:0], 7'b1111111}; // unknown opcode, unique per slot
            exp_next[i]  = 32'(i * 4 + 4);
            exp_rd[i]    = 5'd0;
            exp_we[i]    = 1'b0;
            exp_wdata[i] = 32'd0;
        end
        row_pc = 32'd0;
        put_row(i_type(12'd5, 5'd0, 3'b000, 5'd1, riscv_pkg::opc_op_imm), 5'd1, 32'd5);
        put_row(i_type(12'hffd, 5'd0, 3'b000, 5'd2, riscv_pkg::opc_op_imm), 5'd2, 32'hfffffffd);
        put_row(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 32'd2);
        put_row(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, 32'd8); // sub
        put_row(r_type(7'h20, 5'd1, 5'd2, 3'b101, 5'd5), 5'd5, 32'hffffffff); // sra
        put_row(r_type(7'h00, 5'd1, 5'd2, 3'b101, 5'd6), 5'd6, 32'h07ffffff); // srl
        put_row(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd7), 5'd7, 32'd1);
        put_row(r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd8), 5'd8, 32'd0);
        put_row({20'h12345, 5'd9, 7'b0110111}, 5'd9, 32'h12345000);
        put_row({20'h00001, 5'd10, 7'b0010111}, 5'd10, 32'h00001024); // auipc at 36
        put_row(i_type(12'd7, 5'd1, 3'b000, 5'd0, riscv_pkg::opc_op_imm), 5'd0, 32'd0);
        put_row(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd11), 5'd11, 32'd0);
        put_row(i_type(12'hfff, 5'd1, 3'b100, 5'd12, riscv_pkg::opc_op_imm), 5'd12, 32'hfffffffa);
        put_row(i_type(12'h004, 5'd1, 3'b001, 5'd13, riscv_pkg::opc_op_imm), 5'd13, 32'h50);
        put_row(i_type(12'h0f0, 5'd2, 3'b111, 5'd14, riscv_pkg::opc_op_imm), 5'd14, 32'hf0);
        put_row(r_type(7'h00, 5'd9, 5'd1, 3'b110, 5'd15), 5'd15, 32'h12345005);
        put_row(i_type(12'hfff, 5'd1, 3'b011, 5'd16, riscv_pkg::opc_op_imm), 5'd16, 32'd1);
        put_row(i_type(12'h41f, 5'd2, 3'b101, 5'd17, riscv_pkg::opc_op_imm), 5'd17, 32'hffffffff);
        put_row(s_type(12'd0, 5'd9, 5'd0, 3'b010), 5'd0, 32'd0);
        put_row(s_type(12'd4, 5'd2, 5'd0, 3'b000), 5'd0, 32'd0);
        put_row(s_type(12'd5, 5'd1, 5'd0, 3'b000), 5'd0, 32'd0);
        put_row(s_type(12'd6, 5'd2, 5'd0, 3'b001), 5'd0, 32'd0);
        put_row(i_type(12'd0, 5'd0, 3'b010, 5'd18, riscv_pkg::opc_load), 5'd18, 32'h12345000);
        put_row(i_type(12'd4, 5'd0, 3'b000, 5'd19, riscv_pkg::opc_load), 5'd19, 32'hfffffffd);
        put_row(i_type(12'd4, 5'd0, 3'b100, 5'd20, riscv_pkg::opc_load), 5'd20, 32'h000000fd);
        put_row(i_type(12'd6, 5'd0, 3'b001, 5'd21, riscv_pkg::opc_load), 5'd21, 32'hfffffffd);
        put_row(i_type(12'd6, 5'd0, 3'b101, 5'd22, riscv_pkg::opc_load), 5'd22, 32'h0000fffd);
        put_row(i_type(12'd4, 5'd0, 3'b010, 5'd23, riscv_pkg::opc_load), 5'd23, 32'hfffd05fd);
        put_row(i_type(12'd2, 5'd0, 3'b001, 5'd24, riscv_pkg::opc_load), 5'd24, 32'h00001234);
        // each branch pair: taken over one slot, then not taken
        put_jump(b_type(13'd8, 5'd1, 5'd1, 3'b000), 5'd0, 32'd0, row_pc + 32'd8);
        skip_row();
        put_row(b_type(13'd8, 5'd2, 5'd1, 3'b000), 5'd0, 32'd0);
        put_jump(b_type(13'd8, 5'd2, 5'd1, 3'b001), 5'd0, 32'd0, row_pc + 32'd8);
        skip_row();
        put_row(b_type(13'd8, 5'd1, 5'd1, 3'b001), 5'd0, 32'd0);
        put_jump(b_type(13'd8, 5'd1, 5'd2, 3'b100), 5'd0, 32'd0, row_pc + 32'd8);
        skip_row();
        put_row(b_type(13'd8, 5'd2, 5'd1, 3'b100), 5'd0, 32'd0);
        put_jump(b_type(13'd8, 5'd2, 5'd1, 3'b101), 5'd0, 32'd0, row_pc + 32'd8);
        skip_row();
        put_row(b_type(13'd8, 5'd1, 5'd2, 3'b101), 5'd0, 32'd0);
        put_jump(b_type(13'd8, 5'd2, 5'd1, 3'b110), 5'd0, 32'd0, row_pc + 32'd8);
        skip_row();
        put_row(b_type(13'd8, 5'd1, 5'd2, 3'b110), 5'd0, 32'd0);
        put_jump(b_type(13'd8, 5'd1, 5'd2, 3'b111), 5'd0, 32'd0, row_pc + 32'd8);
        skip_row();
        put_row(b_type(13'd8, 5'd2, 5'd1, 3'b111), 5'd0, 32'd0);
        put_jump(j_type(21'd12, 5'd25), 5'd25, 32'd192, 32'd200); // jal at 188
        skip_row();
        skip_row();
        put_row(i_type(12'd212, 5'd0, 3'b000, 5'd26, riscv_pkg::opc_op_imm), 5'd26, 32'd212);
        put_jump(i_type(12'd1, 5'd26, 3'b000, 5'd27, riscv_pkg::opc_jalr), 5'd27, 32'd208,
                 32'd212);
        skip_row();
        put_row(32'h00000f8b, 5'd0, 32'd0); // custom-0 opcode, rd x31
    endtask

    task automatic build_random();
        logic [31:0] walk_pc;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [31:0] val;
        logic [31:0] inst;
        for (int r = 0; r < 32; r++)
            model[r] = 32'd0;
        walk_pc = 32'd0;
        while (walk_pc < row_pc) begin // replay the fixed part in retire order
            if (exp_we[walk_pc[8:2]])
                model[exp_rd[walk_pc[8:2]]] = exp_wdata[walk_pc[8:2]];
            walk_pc = exp_next[walk_pc[8:2]];
        end
        rng = 32'hf33a;
        for (int k = 0; k < random_count; k++) begin
            rng = xorshift(rng);
            rd  = (rng[4:0] == 5'd0) ? 5'd31 : rng[4:0];
            rs1 = rng[9:5];
            rs2 = rng[14:10];
            imm = rng[26:15];
            if (rng[31]) begin
                inst = r_type(7'h00, rs2, rs1, 3'b100, rd);
                val  = model[rs1] ^ model[rs2];
            end else begin
                inst = i_type(imm, rs1, 3'b000, rd, riscv_pkg::opc_op_imm);
                val  = model[rs1] + {{20{imm[11]}}, imm};
            end
            model[rd] = val;
            put_row(inst, rd, val);
        end
    endtask

    initial begin
        logic [31:0] expect_pc;
        logic [6:0]  idx;
        errors = 0;
        reset  = 1'b1;
        build_program();
        build_random();
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        expect_pc = 32'd0;
        while (expect_pc < row_pc) begin
            wait_retire();
            idx = expect_pc[8:2];
            check_equal("retire_pc", retire_pc, expect_pc);
            check_equal("retire_we", {31'd0, retire_we}, {31'd0, exp_we[idx]});
            if (exp_we[idx]) begin
                check_equal("retire_rd", {27'd0, retire_rd}, {27'd0, exp_rd[idx]});
                check_equal("retire_wdata", retire_wdata, exp_wdata[idx]);
            end
            expect_pc = exp_next[idx];
        end
        if (errors == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("=== FAIL ===");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

//--- compile.f
hdl/riscv_pkg.sv
hdl/riscv_decode.sv
hdl/riscv_control.sv
hdl/riscv_alu.sv
hdl/riscv_branch.sv
hdl/riscv_regfile.sv
hdl/riscv_dmem.sv
hdl/riscv_core.sv
tb/riscv_core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
    --top-module riscv_core_tb --Mdir obj_dir -o riscv_core_tb

./obj_dir/riscv_core_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^=== PASS ===$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
